// ==== include/cipher_ctrl_consts.svh ====
`ifndef CIPHER_CTRL_CONSTS_SVH
`define CIPHER_CTRL_CONSTS_SVH

////////////////////
// Sparse encoding
////////////////////

// One rail per bit of a sparse signal
`define SP2V_WIDTH 3

`define SP2V_HIGH 3'b011  // Asserted
`define SP2V_LOW  3'b100  // Deasserted

////////////////////
// Round control
////////////////////

`define RND_CTR_WIDTH 4

// Rounds per key length
`define NUM_ROUNDS_128 10
`define NUM_ROUNDS_192 12
`define NUM_ROUNDS_256 14

`endif

// ==== hw/sp2v_pkg.sv ====
`include "cipher_ctrl_consts.svh"

package sp2v_pkg;

  ////////////////////
  // Sparse values
  ////////////////////

  // One sparse control value, legal codes are `SP2V_HIGH and `SP2V_LOW
  typedef logic [`SP2V_WIDTH-1:0] sp2v_t;

  ////////////////////
  // Rail bundles
  ////////////////////

  // Bit i belongs to rail i, polarity per rail
  typedef logic [`SP2V_WIDTH-1:0] rail_bits_t;

endpackage

// ==== hw/cipher_pkg.sv ====
`include "cipher_ctrl_consts.svh"

package cipher_pkg;

  ////////////////////
  // Key length
  ////////////////////

  // One-hot, anything else is an encoding error
  typedef enum logic [2:0] {
    KEY_128 = 3'b001,
    KEY_192 = 3'b010,
    KEY_256 = 3'b100
  } key_len_e;

  // Round index, 0 during the initial key addition
  typedef logic [`RND_CTR_WIDTH-1:0] rnd_ctr_t;

  ////////////////////
  // Rail FSM
  ////////////////////

  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    INIT   = 3'd1,
    ROUND  = 3'd2,
    FINISH = 3'd3,
    ERROR  = 3'd4  // Terminal until reset
  } rail_state_e;

endpackage

// ==== hw/ctrl_input_check.sv ====
`timescale 1ns/1ps
`include "cipher_ctrl_consts.svh"

module ctrl_input_check (
  input  sp2v_pkg::sp2v_t        in_valid_i,
  input  sp2v_pkg::sp2v_t        out_ready_i,
  input  cipher_pkg::key_len_e   key_len_i,
  output sp2v_pkg::rail_bits_t   in_valid_bits_o,
  output sp2v_pkg::rail_bits_t   out_ready_bits_o,
  output cipher_pkg::rnd_ctr_t   num_rounds_o,
  output logic                   enc_err_o
);

  logic in_valid_err;
  logic out_ready_err;
  logic key_len_err;

  // Each bit goes to its own rail
  assign in_valid_bits_o  = in_valid_i;
  assign out_ready_bits_o = out_ready_i;

  assign in_valid_err  = !(in_valid_i inside {`SP2V_HIGH, `SP2V_LOW});
  assign out_ready_err = !(out_ready_i inside {`SP2V_HIGH, `SP2V_LOW});

  always_comb begin : key_len_decode
    key_len_err  = 1'b0;
    num_rounds_o = cipher_pkg::rnd_ctr_t'(`NUM_ROUNDS_128);
    case (key_len_i)
      cipher_pkg::KEY_128: num_rounds_o = cipher_pkg::rnd_ctr_t'(`NUM_ROUNDS_128);
      cipher_pkg::KEY_192: num_rounds_o = cipher_pkg::rnd_ctr_t'(`NUM_ROUNDS_192);
      cipher_pkg::KEY_256: num_rounds_o = cipher_pkg::rnd_ctr_t'(`NUM_ROUNDS_256);
      default:             key_len_err  = 1'b1;  // Not one-hot
    endcase
  end

  // Key length only matters while a request is presented
  assign enc_err_o = in_valid_err | out_ready_err |
                     (key_len_err & (in_valid_i == `SP2V_HIGH));

endmodule

// ==== hw/cipher_ctrl_rail.sv ====
`timescale 1ns/1ps

module cipher_ctrl_rail #(
  parameter bit Polarity = 1'b1  // 0: bits are active low on this rail
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  logic                 in_valid_bit_i,
  input  logic                 out_ready_bit_i,
  input  cipher_pkg::rnd_ctr_t num_rounds_i,
  input  logic                 err_i,

  output logic                 in_ready_bit_o,
  output logic                 out_valid_bit_o,
  output logic                 state_we_bit_o,
  output logic                 key_expand_en_bit_o,
  output logic                 alert_o,
  output cipher_pkg::rnd_ctr_t rnd_ctr_o
);

  cipher_pkg::rail_state_e state_d, state_q;
  cipher_pkg::rnd_ctr_t    rnd_ctr_d, rnd_ctr_q;
  cipher_pkg::rnd_ctr_t    num_rounds_q;
  logic                    load_rounds;

  // Active-high view inside the rail
  logic in_valid;
  logic out_ready;
  logic in_ready;
  logic out_valid;
  logic state_we;
  logic key_expand_en;

  assign in_valid  = Polarity ? in_valid_bit_i  : ~in_valid_bit_i;
  assign out_ready = Polarity ? out_ready_bit_i : ~out_ready_bit_i;

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin : rail_fsm
    state_d       = state_q;
    rnd_ctr_d     = rnd_ctr_q;
    load_rounds   = 1'b0;
    in_ready      = 1'b0;
    out_valid     = 1'b0;
    state_we      = 1'b0;
    key_expand_en = 1'b0;
    alert_o       = 1'b0;

    case (state_q)
      cipher_pkg::IDLE: begin
        in_ready = 1'b1;
        if (in_valid) begin
          load_rounds = 1'b1;  // Key length sampled on accept
          state_d     = cipher_pkg::INIT;
        end
      end

      cipher_pkg::INIT: begin  // Initial key addition, round 0
        state_we      = 1'b1;
        key_expand_en = 1'b1;
        rnd_ctr_d     = cipher_pkg::rnd_ctr_t'(1);
        state_d       = cipher_pkg::ROUND;
      end

      cipher_pkg::ROUND: begin
        state_we      = 1'b1;
        key_expand_en = 1'b1;
        if (rnd_ctr_q >= num_rounds_q) begin
          state_d = cipher_pkg::FINISH;  // Counter holds at Nr
        end else begin
          rnd_ctr_d = cipher_pkg::rnd_ctr_t'(rnd_ctr_q + 1'b1);
        end
      end

      cipher_pkg::FINISH: begin
        out_valid = 1'b1;
        if (out_ready) begin
          rnd_ctr_d = '0;
          state_d   = cipher_pkg::IDLE;
        end
      end

      cipher_pkg::ERROR: begin
        alert_o = 1'b1;  // No way out
      end

      default: state_d = cipher_pkg::ERROR;  // Corrupted state register
    endcase

    // Any encoding or counter fault wins
    if (err_i) begin
      state_d = cipher_pkg::ERROR;
    end
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : rail_regs
    if (!rst_ni) begin
      state_q   <= cipher_pkg::IDLE;
      rnd_ctr_q <= '0;
    end else begin
      state_q   <= state_d;
      rnd_ctr_q <= rnd_ctr_d;
    end
  end

  always_ff @(posedge clk_i) begin : rounds_reg
    if (load_rounds) begin
      num_rounds_q <= num_rounds_i;
    end
  end

  // Back to the rail's own polarity
  assign in_ready_bit_o      = Polarity ? in_ready      : ~in_ready;
  assign out_valid_bit_o     = Polarity ? out_valid     : ~out_valid;
  assign state_we_bit_o      = Polarity ? state_we      : ~state_we;
  assign key_expand_en_bit_o = Polarity ? key_expand_en : ~key_expand_en;
  assign rnd_ctr_o           = rnd_ctr_q;

endmodule

// ==== hw/rail_combine.sv ====
`timescale 1ns/1ps
`include "cipher_ctrl_consts.svh"

module rail_combine (
  input  sp2v_pkg::rail_bits_t                   in_ready_bits_i,
  input  sp2v_pkg::rail_bits_t                   out_valid_bits_i,
  input  sp2v_pkg::rail_bits_t                   state_we_bits_i,
  input  sp2v_pkg::rail_bits_t                   key_expand_en_bits_i,
  input  sp2v_pkg::rail_bits_t                   alert_bits_i,
  input  cipher_pkg::rnd_ctr_t [`SP2V_WIDTH-1:0] rnd_ctrs_i,

  output sp2v_pkg::sp2v_t                        in_ready_o,
  output sp2v_pkg::sp2v_t                        out_valid_o,
  output sp2v_pkg::sp2v_t                        state_we_o,
  output sp2v_pkg::sp2v_t                        key_expand_en_o,
  output logic                                   alert_o,
  output cipher_pkg::rnd_ctr_t                   round_o,
  output logic                                   ctr_err_o
);

  ////////////////////
  // Sparse outputs
  ////////////////////

  // Rail i drives bit i, a bad rail shows up as an illegal code
  assign in_ready_o      = sp2v_pkg::sp2v_t'(in_ready_bits_i);
  assign out_valid_o     = sp2v_pkg::sp2v_t'(out_valid_bits_i);
  assign state_we_o      = sp2v_pkg::sp2v_t'(state_we_bits_i);
  assign key_expand_en_o = sp2v_pkg::sp2v_t'(key_expand_en_bits_i);

  assign alert_o = |alert_bits_i;  // One rail is enough

  ////////////////////
  // Round counter
  ////////////////////

  always_comb begin : combine_ctr
    round_o   = '0;
    ctr_err_o = 1'b0;
    for (int i = 0; i < `SP2V_WIDTH; i++) begin
      round_o = round_o | rnd_ctrs_i[i];
    end
    // A rail that lags or leads differs from the OR
    for (int i = 0; i < `SP2V_WIDTH; i++) begin
      if (rnd_ctrs_i[i] != round_o) begin
        ctr_err_o = 1'b1;
      end
    end
  end

endmodule

// ==== hw/cipher_ctrl.sv ====
`timescale 1ns/1ps
`include "cipher_ctrl_consts.svh"

module cipher_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  sp2v_pkg::sp2v_t      in_valid_i,
  input  sp2v_pkg::sp2v_t      out_ready_i,
  input  cipher_pkg::key_len_e key_len_i,

  output sp2v_pkg::sp2v_t      in_ready_o,
  output sp2v_pkg::sp2v_t      out_valid_o,
  output sp2v_pkg::sp2v_t      state_we_o,
  output sp2v_pkg::sp2v_t      key_expand_en_o,
  output cipher_pkg::rnd_ctr_t round_o,
  output logic                 alert_o
);

  // Rail polarity follows the asserted code
  localparam sp2v_pkg::sp2v_t high_code = `SP2V_HIGH;

  sp2v_pkg::rail_bits_t                   in_valid_bits, out_ready_bits;
  sp2v_pkg::rail_bits_t                   in_ready_bits, out_valid_bits;
  sp2v_pkg::rail_bits_t                   state_we_bits, key_expand_en_bits;
  sp2v_pkg::rail_bits_t                   alert_bits;
  cipher_pkg::rnd_ctr_t [`SP2V_WIDTH-1:0] rnd_ctrs;
  cipher_pkg::rnd_ctr_t                   num_rounds;
  logic                                   enc_err;
  logic                                   ctr_err;
  logic                                   rail_err;

  ctrl_input_check u_input_check (
    .in_valid_i       ( in_valid_i     ),
    .out_ready_i      ( out_ready_i    ),
    .key_len_i        ( key_len_i      ),
    .in_valid_bits_o  ( in_valid_bits  ),
    .out_ready_bits_o ( out_ready_bits ),
    .num_rounds_o     ( num_rounds     ),
    .enc_err_o        ( enc_err        )
  );

  assign rail_err = enc_err | ctr_err;  // Seen by every rail

  ////////////////////
  // Rails
  ////////////////////

  for (genvar i = 0; i < `SP2V_WIDTH; i++) begin : gen_rail
    cipher_ctrl_rail #(
      .Polarity ( high_code[i] )
    ) u_rail (
      .clk_i               ( clk_i                 ),
      .rst_ni              ( rst_ni                ),
      .in_valid_bit_i      ( in_valid_bits[i]      ),
      .out_ready_bit_i     ( out_ready_bits[i]     ),
      .num_rounds_i        ( num_rounds            ),
      .err_i               ( rail_err              ),
      .in_ready_bit_o      ( in_ready_bits[i]      ),
      .out_valid_bit_o     ( out_valid_bits[i]     ),
      .state_we_bit_o      ( state_we_bits[i]      ),
      .key_expand_en_bit_o ( key_expand_en_bits[i] ),
      .alert_o             ( alert_bits[i]         ),
      .rnd_ctr_o           ( rnd_ctrs[i]           )
    );
  end

  rail_combine u_combine (
    .in_ready_bits_i      ( in_ready_bits      ),
    .out_valid_bits_i     ( out_valid_bits     ),
    .state_we_bits_i      ( state_we_bits      ),
    .key_expand_en_bits_i ( key_expand_en_bits ),
    .alert_bits_i         ( alert_bits         ),
    .rnd_ctrs_i           ( rnd_ctrs           ),
    .in_ready_o           ( in_ready_o         ),
    .out_valid_o          ( out_valid_o        ),
    .state_we_o           ( state_we_o         ),
    .key_expand_en_o      ( key_expand_en_o    ),
    .alert_o              ( alert_o            ),
    .round_o              ( round_o            ),
    .ctr_err_o            ( ctr_err            )
  );

endmodule

// ==== tests/cipher_ctrl_sva.sv ====
`timescale 1ns/1ps
`include "cipher_ctrl_consts.svh"

module cipher_ctrl_sva (
  input logic            clk_i,
  input logic            rst_ni,
  input sp2v_pkg::sp2v_t in_ready_i,
  input sp2v_pkg::sp2v_t out_valid_i,
  input sp2v_pkg::sp2v_t state_we_i,
  input logic            alert_i
);

  // Input and output side never open at once
  handshake_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(in_ready_i == `SP2V_HIGH && out_valid_i == `SP2V_HIGH))
    else $error("in_ready_o and out_valid_o asserted together");

  state_we_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_we_i == `SP2V_HIGH) || (state_we_i == `SP2V_LOW))
    else $error("state_we_o carries an illegal sparse code");

  // Only reset clears the alert
  alert_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_i |=> alert_i)
    else $error("alert_o dropped without reset");

endmodule

// ==== tests/cipher_ctrl_monitor.sv ====
`timescale 1ns/1ps
`include "cipher_ctrl_consts.svh"

module cipher_ctrl_monitor (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  sp2v_pkg::sp2v_t      in_valid_i,
  input  sp2v_pkg::sp2v_t      out_ready_i,
  input  logic [2:0]           key_len_i,
  input  cipher_pkg::rnd_ctr_t exp_rounds_i,  // Nr of the running test
  input  logic [8*10-1:0]      test_name_i,
  input  sp2v_pkg::sp2v_t      in_ready_i,
  input  sp2v_pkg::sp2v_t      out_valid_i,
  input  sp2v_pkg::sp2v_t      state_we_i,
  input  sp2v_pkg::sp2v_t      key_expand_en_i,
  input  cipher_pkg::rnd_ctr_t round_i,
  input  logic                 alert_i,
  output int                   error_count_o,
  output int                   check_count_o
);

  localparam int MIdle  = 0;
  localparam int MBusy  = 1;  // Round 0 up to Nr
  localparam int MDone  = 2;
  localparam int MFault = 3;

  int errors  = 0;
  int checks  = 0;
  int m_state = MIdle;
  int m_round = 0;
  int m_nr    = 0;

  assign error_count_o = errors;
  assign check_count_o = checks;

  function automatic bit legal(input sp2v_pkg::sp2v_t v);
    return (v == `SP2V_HIGH) || (v == `SP2V_LOW);
  endfunction

  function automatic int code(input bit on);
    return on ? int'(`SP2V_HIGH) : int'(`SP2V_LOW);
  endfunction

  task automatic compare(input string what, input int expected, input int actual);
    checks++;
    if (expected != actual) begin
      errors++;
      $display("[ERROR] %s: %s expected 0x%0h actual 0x%0h",
               test_name_i, what, expected, actual);
    end
  endtask

  ////////////////////
  // Compare
  ////////////////////

  task automatic check_outputs();
    if (m_state == MFault) begin
      compare("alert_o", 1, int'(alert_i));
      compare("in_ready_o", int'(`SP2V_LOW), int'(in_ready_i));
      compare("out_valid_o", int'(`SP2V_LOW), int'(out_valid_i));
      compare("state_we_o", int'(`SP2V_LOW), int'(state_we_i));
    end else begin
      compare("alert_o", 0, int'(alert_i));
      compare("in_ready_o", code(m_state == MIdle), int'(in_ready_i));
      compare("out_valid_o", code(m_state == MDone), int'(out_valid_i));
      compare("state_we_o", code(m_state == MBusy), int'(state_we_i));
      compare("key_expand_en_o", code(m_state == MBusy), int'(key_expand_en_i));
      compare("round_o", m_round, int'(round_i));
    end
  endtask

  ////////////////////
  // Predict
  ////////////////////

  task automatic advance(input bit fault);
    if (fault) begin
      m_state = MFault;  // Terminal until reset
    end else begin
      case (m_state)
        MIdle: begin
          if (in_valid_i == `SP2V_HIGH) begin
            m_state = MBusy;
            m_round = 0;
            m_nr    = int'(exp_rounds_i);
          end
        end
        MBusy: begin
          if (m_round == m_nr) begin
            m_state = MDone;  // Round held at Nr
          end else begin
            m_round++;
          end
        end
        MDone: begin
          if (out_ready_i == `SP2V_HIGH) begin
            m_state = MIdle;
            m_round = 0;
          end
        end
        default: ;
      endcase
    end
  endtask

  // Inputs move 10 ns after the rising edge, so the falling edge sees both sides settled
  always @(negedge clk_i) begin : check_and_predict
    bit fault;
    if (!rst_ni) begin
      m_state = MIdle;
      m_round = 0;
    end else begin
      check_outputs();
      fault = !legal(in_valid_i) || !legal(out_ready_i) ||
              (in_valid_i == `SP2V_HIGH && !$onehot(key_len_i));
      advance(fault);
    end
  end

endmodule

// ==== tests/cipher_ctrl_tb.sv ====
`timescale 1ns/1ps
`include "cipher_ctrl_consts.svh"

module cipher_ctrl_tb;

  localparam int NumTests  = 9;
  localparam int WaitLimit = 40;  // Cycles

  localparam int FaultNone     = 0;
  localparam int FaultInValid  = 1;
  localparam int FaultOutReady = 2;
  localparam int FaultKeyLen   = 3;

  logic                 clk;
  logic                 rst_n;
  sp2v_pkg::sp2v_t      in_valid;
  sp2v_pkg::sp2v_t      out_ready;
  cipher_pkg::key_len_e key_len;
  sp2v_pkg::sp2v_t      in_ready;
  sp2v_pkg::sp2v_t      out_valid;
  sp2v_pkg::sp2v_t      state_we;
  sp2v_pkg::sp2v_t      key_expand_en;
  cipher_pkg::rnd_ctr_t round;
  logic                 alert;
  cipher_pkg::rnd_ctr_t exp_rounds;
  logic [8*10-1:0]      test_name;
  int                   error_count;
  int                   check_count;
  int                   timeout_count;
  logic [31:0]          lfsr;

  ////////////////////
  // Stimulus table
  ////////////////////

  logic [8*10-1:0] tbl_name  [NumTests];
  logic [2:0]      tbl_key   [NumTests];
  int              tbl_delay [NumTests];  // Negative means draw from LFSR
  int              tbl_fault [NumTests];
  int              tbl_nr    [NumTests];  // Expected round count

  task automatic add_row(input int i, input logic [8*10-1:0] name, input logic [2:0] key,
                         input int delay, input int fault, input int nr);
    tbl_name[i]  = name;
    tbl_key[i]   = key;
    tbl_delay[i] = delay;
    tbl_fault[i] = fault;
    tbl_nr[i]    = nr;
  endtask

  task automatic fill_table();
    add_row(0, "key128    ", 3'b001, 2, FaultNone, 10);
    add_row(1, "key192    ", 3'b010, 0, FaultNone, 12);
    add_row(2, "key256    ", 3'b100, 1, FaultNone, 14);
    add_row(3, "rand_bp_a ", 3'b001, -1, FaultNone, 10);
    add_row(4, "rand_bp_b ", 3'b100, -1, FaultNone, 14);
    add_row(5, "rand_bp_c ", 3'b010, -1, FaultNone, 12);
    add_row(6, "bad_valid ", 3'b001, 0, FaultInValid, 10);
    add_row(7, "bad_ready ", 3'b010, 3, FaultOutReady, 12);
    add_row(8, "bad_keylen", 3'b011, 0, FaultKeyLen, 0);
  endtask

  cipher_ctrl cipher_ctrl_i (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .in_valid_i      ( in_valid      ),
    .out_ready_i     ( out_ready     ),
    .key_len_i       ( key_len       ),
    .in_ready_o      ( in_ready      ),
    .out_valid_o     ( out_valid     ),
    .state_we_o      ( state_we      ),
    .key_expand_en_o ( key_expand_en ),
    .round_o         ( round         ),
    .alert_o         ( alert         )
  );

  cipher_ctrl_monitor u_monitor (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .in_valid_i      ( in_valid      ),
    .out_ready_i     ( out_ready     ),
    .key_len_i       ( key_len       ),
    .exp_rounds_i    ( exp_rounds    ),
    .test_name_i     ( test_name     ),
    .in_ready_i      ( in_ready      ),
    .out_valid_i     ( out_valid     ),
    .state_we_i      ( state_we      ),
    .key_expand_en_i ( key_expand_en ),
    .round_i         ( round         ),
    .alert_i         ( alert         ),
    .error_count_o   ( error_count   ),
    .check_count_o   ( check_count   )
  );

  bind cipher_ctrl cipher_ctrl_sva u_sva (
    .clk_i      ( clk_i       ),
    .rst_ni     ( rst_ni      ),
    .in_ready_i ( in_ready_o  ),
    .out_valid_i( out_valid_o ),
    .state_we_i ( state_we_o  ),
    .alert_i    ( alert_o     )
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);  // One step per bit
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic step();
    @(posedge clk);
    #10;
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #10;
    rst_n = 1'b1;
  endtask

  task automatic wait_high(input bit for_out_valid, output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < WaitLimit) begin
      if ((for_out_valid ? out_valid : in_ready) == `SP2V_HIGH) begin
        ok = 1'b1;
      end else begin
        step();
        n++;
      end
    end
    if (!ok) begin
      timeout_count++;
      $display("Timeout in %s: %s never went high", test_name,
               for_out_valid ? "out_valid_o" : "in_ready_o");
    end
  endtask

  task automatic run_row(input int i, input int delay, output bit ok);
    ok = 1'b1;
    if (tbl_fault[i] == FaultKeyLen) begin
      key_len = cipher_pkg::key_len_e'(tbl_key[i]);
      repeat (3) step();  // Ignored while in_valid is low
    end
    wait_high(1'b0, ok);
    if (!ok) return;
    in_valid = (tbl_fault[i] == FaultInValid) ? 3'b001 : `SP2V_HIGH;
    key_len  = cipher_pkg::key_len_e'(tbl_key[i]);
    step();
    in_valid = `SP2V_LOW;
    key_len  = cipher_pkg::key_len_e'({tbl_key[i][1:0], tbl_key[i][2]});  // Sampled on accept only
    if (tbl_fault[i] == FaultInValid || tbl_fault[i] == FaultKeyLen) begin
      repeat (3) step();  // Alert has to hold
      return;
    end
    wait_high(1'b1, ok);
    if (!ok) return;
    repeat (delay) step();  // Back-pressure
    out_ready = (tbl_fault[i] == FaultOutReady) ? 3'b000 : `SP2V_HIGH;
    step();
    out_ready = `SP2V_LOW;
    if (tbl_fault[i] == FaultOutReady) begin
      repeat (3) step();
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin : main
    bit ok;
    bit need_reset;
    int delay;
    rst_n         = 1'b0;
    in_valid      = `SP2V_LOW;
    out_ready     = `SP2V_LOW;
    key_len       = cipher_pkg::KEY_128;
    exp_rounds    = '0;
    test_name     = "reset     ";
    timeout_count = 0;
    lfsr          = 32'h6eac_f546;
    ok            = 1'b1;
    need_reset    = 1'b0;
    fill_table();
    apply_reset();

    for (int i = 0; i < NumTests && ok; i++) begin
      if (need_reset) begin
        apply_reset();  // ERROR only leaves through reset
      end
      test_name  = tbl_name[i];
      exp_rounds = cipher_pkg::rnd_ctr_t'(tbl_nr[i]);
      if (tbl_delay[i] < 0) begin
        take_bits(3, delay);
      end else begin
        delay = tbl_delay[i];
      end
      run_row(i, delay, ok);
      need_reset = (tbl_fault[i] != FaultNone);
    end
    step();
    step();

    $display("Checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== cipher_ctrl.f ====
+incdir+include
hw/sp2v_pkg.sv
hw/cipher_pkg.sv
hw/ctrl_input_check.sv
hw/cipher_ctrl_rail.sv
hw/rail_combine.sv
hw/cipher_ctrl.sv
tests/cipher_ctrl_sva.sv
tests/cipher_ctrl_monitor.sv
tests/cipher_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cipher_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f cipher_ctrl.f --top-module cipher_ctrl_tb -Mdir build -o sim

# The log decides the verdict, so an aborted run still gets graded
./build/sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
  exit 0
else
  exit 1
fi
